// File: branch_predictor.f
bp_pkg.sv
bp_history_table.sv
bp_counter_table.sv
bp_target_buffer.sv
bp_lookup_pipe.sv
branch_predictor.sv
branch_predictor_chk.sv
branch_predictor_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module branch_predictor_tb \
    --Mdir obj_dir \
    -o branch_predictor_sim \
    -f branch_predictor.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit "$build_status"
fi

./obj_dir/branch_predictor_sim
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit "$sim_status"
fi

exit 0

// File: branch_predictor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

module branch_predictor_tb;

    import bp_pkg::*;

    localparam int CLK_PERIOD_NS  = 100;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DELAY_NS = 1;
    localparam int MARGIN_CYCLES  = 40;

    localparam logic [PC_W-1:0]  TRAIN_PC    = 32'h0000_1040;
    localparam logic [TGT_W-1:0] TRAIN_TGT   = 31'h0000_2200;
    // Same history and BTB index as TRAIN_PC but another tag
    localparam logic [PC_W-1:0]  ALIAS_PC    = 32'h0000_3040;
    // Same BTB index only
    localparam logic [PC_W-1:0]  BTB_ONLY_PC = 32'h0000_1240;

    typedef enum logic [1:0] {
        ROW_IDLE   = 2'd0,
        ROW_LOOKUP = 2'd1,
        ROW_UPDATE = 2'd2
    } row_kind_e;

    typedef struct packed {
        row_kind_e        kind;
        logic [PC_W-1:0]  pc;
        logic             taken;
        logic [TGT_W-1:0] target;
    } stim_row_t;

    typedef struct packed {
        logic [31:0]     due_cycle;
        logic [PC_W-1:0] pc;
        logic            taken;
        logic [PC_W-1:0] next_pc;
    } expect_t;

    logic            clk;
    logic            rst;
    logic            pred_req;
    logic [PC_W-1:0] pred_pc;
    logic            pred_valid;
    bp_prediction_t  pred;
    logic [PC_W-1:0] pred_next_pc;
    logic            upd_valid;
    bp_update_t      upd;

    stim_row_t   rows[$];
    expect_t     expected[$];
    logic [31:0] cycle = '0;
    logic        table_ready = 1'b0;
    int          seed = 12730;

    // Behavioral tables
    logic [HIST_W-1:0] ref_hist [HIST_ENTRIES];
    int                ref_cnt [CNT_ENTRIES];
    logic [TAG_W-1:0]  ref_tag [BTB_ENTRIES];
    logic [TGT_W-1:0]  ref_target [BTB_ENTRIES];
    logic              ref_valid [BTB_ENTRIES];

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) u_clk (.clk_o(clk));

    branch_predictor DUT (
        .clk_i          (clk),
        .rst_i          (rst),
        .pred_req_i     (pred_req),
        .pred_pc_i      (pred_pc),
        .pred_valid_o   (pred_valid),
        .pred_o         (pred),
        .pred_next_pc_o (pred_next_pc),
        .upd_valid_i    (upd_valid),
        .upd_i          (upd)
    );

    always @(posedge clk) begin
        cycle <= cycle + 32'd1;
    end

    task automatic check_value(input string what, input logic [63:0] actual,
                               input logic [63:0] exp_value);
        if (actual !== exp_value) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, exp_value);
            $display("Simulation FAILED");
            $fatal(1, "Value mismatch on %s", what);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < HIST_ENTRIES; i++) begin
            ref_hist[i] = '0;
        end
        for (int i = 0; i < CNT_ENTRIES; i++) begin
            ref_cnt[i] = 0;
        end
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
        end
    endtask

    // Counter values 0 strong NT up to 3 strong T
    task automatic apply_to_model(input stim_row_t row);
        logic [HIST_W-1:0] old_hist;
        old_hist = ref_hist[row.pc[9:2]];
        ref_hist[row.pc[9:2]] = {old_hist[HIST_W-2:0], row.taken};
        if (row.taken && ref_cnt[old_hist] < 3) begin
            ref_cnt[old_hist] = ref_cnt[old_hist] + 1;
        end else if (!row.taken && ref_cnt[old_hist] > 0) begin
            ref_cnt[old_hist] = ref_cnt[old_hist] - 1;
        end
        ref_tag[row.pc[8:2]]    = row.pc[31:2];
        ref_target[row.pc[8:2]] = row.target;
        ref_valid[row.pc[8:2]]  = 1'b1;
    endtask

    function automatic expect_t predict_from_model(input logic [PC_W-1:0] pc,
                                                   input logic [31:0] due);
        expect_t e;
        logic    hit;
        hit = ref_valid[pc[8:2]] && (ref_tag[pc[8:2]] == pc[31:2]);
        e.due_cycle = due;
        e.pc        = pc;
        e.taken     = (ref_cnt[ref_hist[pc[9:2]]] >= 2) && hit;
        e.next_pc   = e.taken ? {ref_target[pc[8:2]], 1'b0} : pc + 32'd4;
        return e;
    endfunction

    task automatic lookup_row(input logic [PC_W-1:0] pc);
        stim_row_t row;
        row        = '0;
        row.kind   = ROW_LOOKUP;
        row.pc     = pc;
        rows.push_back(row);
    endtask

    task automatic update_row(input logic [PC_W-1:0] pc, input logic taken,
                              input logic [TGT_W-1:0] target);
        stim_row_t row;
        row.kind   = ROW_UPDATE;
        row.pc     = pc;
        row.taken  = taken;
        row.target = target;
        rows.push_back(row);
    endtask

    task automatic idle_rows(input int n);
        for (int i = 0; i < n; i++) begin
            rows.push_back('0);
        end
    endtask

    task automatic build_table();
        logic [PC_W-1:0] cold_pc [4];
        logic [PC_W-1:0] rand_pc [8];
        logic [31:0]     rnd;
        // Cold lookups right after reset
        for (int i = 0; i < 4; i++) begin
            cold_pc[i] = $random(seed) & 32'hFFFF_FFFC;
            lookup_row(cold_pc[i]);
            idle_rows(3);
        end
        // Taken run on one branch
        for (int i = 1; i <= 16; i++) begin
            update_row(TRAIN_PC, 1'b1, TRAIN_TGT);
            if (i % 4 == 0) begin
                lookup_row(TRAIN_PC);
                idle_rows(3);
            end
        end
        lookup_row(ALIAS_PC);
        idle_rows(3);
        lookup_row(BTB_ONLY_PC);
        idle_rows(3);
        // Back-to-back lookups with two in flight
        lookup_row(TRAIN_PC);
        lookup_row(ALIAS_PC);
        lookup_row(cold_pc[0]);
        lookup_row(TRAIN_PC);
        lookup_row(BTB_ONLY_PC);
        idle_rows(3);
        // Random branches with random outcomes
        for (int i = 0; i < 8; i++) begin
            rnd        = $random(seed);
            rand_pc[i] = $random(seed) & 32'hFFFF_FFFC;
            update_row(rand_pc[i], rnd[0], rnd[31:1]);
        end
        for (int i = 0; i < 8; i++) begin
            lookup_row(rand_pc[i]);
        end
        idle_rows(3);
        // Not-taken run walks the prediction back
        for (int i = 0; i < 6; i++) begin
            update_row(TRAIN_PC, 1'b0, TRAIN_TGT);
            lookup_row(TRAIN_PC);
            idle_rows(3);
        end
        // History back to all ones, where the counter sits one step below the top
        for (int i = 0; i < HIST_W; i++) begin
            update_row(TRAIN_PC, 1'b1, TRAIN_TGT);
        end
        lookup_row(TRAIN_PC);
        idle_rows(3);
        // Untrained branch keeps history zero and drives its counter to the floor
        for (int i = 0; i < 6; i++) begin
            update_row(cold_pc[1], 1'b0, TRAIN_TGT);
            lookup_row(cold_pc[1]);
            idle_rows(3);
        end
    endtask

    task automatic drive_row(input stim_row_t row);
        pred_req   = (row.kind == ROW_LOOKUP);
        pred_pc    = row.pc;
        upd_valid  = (row.kind == ROW_UPDATE);
        upd.pc     = row.pc;
        upd.taken  = row.taken;
        upd.target = row.target;
        if (row.kind == ROW_LOOKUP) begin
            expected.push_back(predict_from_model(row.pc, cycle + 32'd2));
        end else if (row.kind == ROW_UPDATE) begin
            apply_to_model(row);
        end
    endtask

    // Mid-cycle sampling of the prediction port
    always @(negedge clk) begin : monitor
        expect_t head;
        logic    due;
        if (!rst) begin
            due = (expected.size() != 0) && (expected[0].due_cycle == cycle);
            check_value("pred_valid_o", 64'(pred_valid), 64'(due));
            if (due) begin
                head = expected.pop_front();
                check_value("pred_o.pc", 64'(pred.pc), 64'(head.pc));
                check_value("pred_o.taken", 64'(pred.taken), 64'(head.taken));
                check_value("pred_next_pc_o", 64'(pred_next_pc), 64'(head.next_pc));
            end
        end
    end

    initial begin : watchdog
        wait (table_ready);
        #((rows.size() + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired before the test sequence finished");
    end

    initial begin : main
        rst       = 1'b1;
        pred_req  = 1'b0;
        pred_pc   = '0;
        upd_valid = 1'b0;
        upd       = '0;
        clear_model();
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #(DRIVE_DELAY_NS);
            drive_row(rows[i]);
        end
        @(posedge clk);
        #(DRIVE_DELAY_NS);
        drive_row('0);
        repeat (4) @(posedge clk);
        if (expected.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("%0d expected predictions never arrived", expected.size());
            $display("Simulation FAILED");
            $fatal(1, "Predictions missing at end of run");
        end
    end

endmodule

`default_nettype wire

// File: branch_predictor_chk.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_chk (
    input wire                         clk_i,
    input wire                         rst_i,
    input wire                         pred_req_i,
    input wire                         pred_valid_i,
    input wire bp_pkg::bp_prediction_t pred_i,
    input wire [bp_pkg::PC_W-1:0]      pred_next_pc_i
);

    import bp_pkg::*;

    // Two register stages from request to prediction
    a_valid_follows_req: assert property (
        @(posedge clk_i) disable iff (rst_i)
        pred_valid_i == $past(pred_req_i, 2)
    ) else $error("pred_valid_o does not follow pred_req_i by two cycles");

    a_quiet_in_reset: assert property (
        @(posedge clk_i)
        rst_i && $past(rst_i) |-> !pred_valid_i
    ) else $error("pred_valid_o high during reset");

    a_not_taken_next_pc: assert property (
        @(posedge clk_i) disable iff (rst_i)
        pred_valid_i && !pred_i.taken |-> pred_next_pc_i == pred_i.pc + PC_W'(4)
    ) else $error("Not-taken prediction with next PC other than PC plus 4");

endmodule

bind branch_predictor branch_predictor_chk u_chk (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .pred_req_i     (pred_req_i),
    .pred_valid_i   (pred_valid_o),
    .pred_i         (pred_o),
    .pred_next_pc_i (pred_next_pc_o)
);

`default_nettype wire

// File: branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  wire                      clk_i,
    input  wire                      rst_i,

    input  wire                      pred_req_i,
    input  wire [bp_pkg::PC_W-1:0]   pred_pc_i,

    output logic                     pred_valid_o,
    output bp_pkg::bp_prediction_t   pred_o,
    output logic [bp_pkg::PC_W-1:0]  pred_next_pc_o,

    input  wire                      upd_valid_i,
    input  wire bp_pkg::bp_update_t  upd_i
);

    import bp_pkg::*;

    logic [HIST_IDX_W-1:0] hist_raddr;
    logic [HIST_W-1:0]     hist_rdata;
    logic [HIST_W-1:0]     hist_wold;

    logic [HIST_W-1:0] cnt_raddr;
    counter_state_e    cnt_rdata;

    logic [PC_W-1:0]  btb_pc;
    logic             btb_hit;
    logic [TGT_W-1:0] btb_target;

    bp_lookup_pipe u_lookup (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (pred_req_i),
        .pc_i         (pred_pc_i),
        .hist_raddr_o (hist_raddr),
        .hist_rdata_i (hist_rdata),
        .btb_pc_o     (btb_pc),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .cnt_raddr_o  (cnt_raddr),
        .cnt_rdata_i  (cnt_rdata),
        .valid_o      (pred_valid_o),
        .pred_o       (pred_o),
        .next_pc_o    (pred_next_pc_o)
    );

    // 256 local histories
    bp_history_table u_history (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr_i  (hist_raddr),
        .rdata_o  (hist_rdata),
        .wen_i    (upd_valid_i),
        .waddr_i  (upd_i.pc[HIST_IDX_W+1:2]),
        .wtaken_i (upd_i.taken),
        .wold_o   (hist_wold)
    );

    // Counter moves at the history seen before this update
    bp_counter_table u_counter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr_i  (cnt_raddr),
        .rdata_o  (cnt_rdata),
        .wen_i    (upd_valid_i),
        .waddr_i  (hist_wold),
        .wtaken_i (upd_i.taken)
    );

    bp_target_buffer u_btb (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rpc_i     (btb_pc),
        .hit_o     (btb_hit),
        .rtarget_o (btb_target),
        .wen_i     (upd_valid_i),
        .wpc_i     (upd_i.pc),
        .wtarget_i (upd_i.target)
    );

endmodule

`default_nettype wire

// File: bp_lookup_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module bp_lookup_pipe (
    input  wire                           clk_i,
    input  wire                           rst_i,

    input  wire                           req_i,
    input  wire [bp_pkg::PC_W-1:0]        pc_i,

    output logic [bp_pkg::HIST_IDX_W-1:0] hist_raddr_o,
    input  wire [bp_pkg::HIST_W-1:0]      hist_rdata_i,

    output logic [bp_pkg::PC_W-1:0]       btb_pc_o,
    input  wire                           btb_hit_i,
    input  wire [bp_pkg::TGT_W-1:0]       btb_target_i,

    output logic [bp_pkg::HIST_W-1:0]     cnt_raddr_o,
    input  wire bp_pkg::counter_state_e   cnt_rdata_i,

    output logic                          valid_o,
    output bp_pkg::bp_prediction_t        pred_o,
    output logic [bp_pkg::PC_W-1:0]       next_pc_o
);

    import bp_pkg::*;

    // Stage 1 state
    logic             s1_valid_q;
    logic [PC_W-1:0]  s1_pc_q;
    logic [HIST_W-1:0] s1_hist_q;
    logic             s1_hit_q;
    logic [TGT_W-1:0] s1_target_q;

    logic           s2_taken;
    logic [PC_W-1:0] s2_next_pc;
    bp_prediction_t s2_pred;

    assign hist_raddr_o = pc_i[HIST_IDX_W+1:2];
    assign btb_pc_o     = pc_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_pc_q     <= pc_i;
        s1_hist_q   <= hist_rdata_i;
        s1_hit_q    <= btb_hit_i;
        s1_target_q <= btb_target_i;
    end

    // Stage 2, history selects the counter
    assign cnt_raddr_o = s1_hist_q;

    // Taken needs both a taken-leaning counter and a tag hit
    assign s2_taken   = cnt_rdata_i[1] && s1_hit_q;
    assign s2_next_pc = s2_taken ? {s1_target_q, 1'b0} : s1_pc_q + PC_W'(4);

    always_comb begin
        s2_pred.pc    = s1_pc_q;
        s2_pred.taken = s2_taken;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= s1_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        pred_o    <= s2_pred;
        next_pc_o <= s2_next_pc;
    end

endmodule

`default_nettype wire

// File: bp_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module bp_target_buffer (
    input  wire                      clk_i,
    input  wire                      rst_i,

    input  wire [bp_pkg::PC_W-1:0]   rpc_i,
    output logic                     hit_o,
    output logic [bp_pkg::TGT_W-1:0] rtarget_o,

    input  wire                      wen_i,
    input  wire [bp_pkg::PC_W-1:0]   wpc_i,
    input  wire [bp_pkg::TGT_W-1:0]  wtarget_i
);

    import bp_pkg::*;

    btb_entry_t             entry_q [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] valid_q;

    logic [BTB_IDX_W-1:0] ridx;
    logic [BTB_IDX_W-1:0] widx;
    logic [TAG_W-1:0]     rtag;
    btb_entry_t           rentry;
    btb_entry_t           wentry;

    // Word-aligned PCs, index from the low bits above the byte offset
    assign ridx = rpc_i[BTB_IDX_W+1:2];
    assign widx = wpc_i[BTB_IDX_W+1:2];
    assign rtag = rpc_i[PC_W-1:PC_W-TAG_W];

    assign rentry = entry_q[ridx];

    assign hit_o     = valid_q[ridx] && (rentry.tag == rtag);
    assign rtarget_o = rentry.target;

    always_comb begin
        wentry.tag    = wpc_i[PC_W-1:PC_W-TAG_W];
        wentry.target = wtarget_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wen_i) begin
            valid_q[widx] <= 1'b1;
        end
    end

    // Payload, qualified by valid_q
    always_ff @(posedge clk_i) begin
        if (wen_i) begin
            entry_q[widx] <= wentry;
        end
    end

endmodule

`default_nettype wire

// File: bp_counter_table.sv
`timescale 1ns/1ps
`default_nettype none

module bp_counter_table (
    input  wire                       clk_i,
    input  wire                       rst_i,

    input  wire [bp_pkg::HIST_W-1:0]  raddr_i,
    output bp_pkg::counter_state_e    rdata_o,

    input  wire                       wen_i,
    input  wire [bp_pkg::HIST_W-1:0]  waddr_i,
    input  wire                       wtaken_i
);

    import bp_pkg::*;

    counter_state_e cnt_q [CNT_ENTRIES];
    counter_state_e cnt_old;
    counter_state_e cnt_new;

    assign rdata_o = cnt_q[raddr_i];
    assign cnt_old = cnt_q[waddr_i];

    // One step per update, saturating at both ends
    always_comb begin
        unique case (cnt_old)
            CNT_STRONG_NT: cnt_new = wtaken_i ? CNT_WEAK_NT : CNT_STRONG_NT;
            CNT_WEAK_NT:   cnt_new = wtaken_i ? CNT_WEAK_T : CNT_STRONG_NT;
            CNT_WEAK_T:    cnt_new = wtaken_i ? CNT_STRONG_T : CNT_WEAK_NT;
            CNT_STRONG_T:  cnt_new = wtaken_i ? CNT_STRONG_T : CNT_WEAK_T;
            default:       cnt_new = CNT_STRONG_NT;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < CNT_ENTRIES; i++) begin
                cnt_q[i] <= CNT_STRONG_NT;
            end
        end else if (wen_i) begin
            cnt_q[waddr_i] <= cnt_new;
        end
    end

endmodule

`default_nettype wire

// File: bp_history_table.sv
`timescale 1ns/1ps
`default_nettype none

module bp_history_table (
    input  wire                          clk_i,
    input  wire                          rst_i,

    input  wire [bp_pkg::HIST_IDX_W-1:0] raddr_i,
    output logic [bp_pkg::HIST_W-1:0]    rdata_o,

    input  wire                          wen_i,
    input  wire [bp_pkg::HIST_IDX_W-1:0] waddr_i,
    input  wire                          wtaken_i,
    output logic [bp_pkg::HIST_W-1:0]    wold_o
);

    import bp_pkg::*;

    logic [HIST_W-1:0] hist_q [HIST_ENTRIES];

    // Lookup port, combinational
    assign rdata_o = hist_q[raddr_i];

    // Pre-update history, also the counter write address
    assign wold_o = hist_q[waddr_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < HIST_ENTRIES; i++) begin
                hist_q[i] <= '0;
            end
        end else if (wen_i) begin
            // Newest outcome enters at bit 0
            hist_q[waddr_i] <= {wold_o[HIST_W-2:0], wtaken_i};
        end
    end

endmodule

`default_nettype wire

// File: bp_pkg.sv
`default_nettype none

package bp_pkg;

    localparam int PC_W       = 32;
    localparam int HIST_W     = 10;
    localparam int HIST_IDX_W = 8;
    localparam int BTB_IDX_W  = 7;
    localparam int TAG_W      = 30;
    localparam int TGT_W      = 31;

    localparam int HIST_ENTRIES = 1 << HIST_IDX_W;
    localparam int CNT_ENTRIES  = 1 << HIST_W;
    localparam int BTB_ENTRIES  = 1 << BTB_IDX_W;

    // Upper bit set means predict taken
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_state_e;

    // Resolved branch from the execute side
    typedef struct packed {
        logic [PC_W-1:0]  pc;
        logic             taken;
        logic [TGT_W-1:0] target;
    } bp_update_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        logic            taken;
    } bp_prediction_t;

    // Tag is PC[31:2], target drops bit 0
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [TGT_W-1:0] target;
    } btb_entry_t;

endpackage

`default_nettype wire
